/* include/mem_ops.svh */
`ifndef MEM_OPS_SVH
`define MEM_OPS_SVH

// load access types where the U forms zero-extend
`define MEM_LB   3'd0
`define MEM_LH   3'd1
`define MEM_LW   3'd2
`define MEM_LBU  3'd3
`define MEM_LHU  3'd4

// store access types
`define MEM_SB   3'd5
`define MEM_SH   3'd6
`define MEM_SW   3'd7

`endif

/* src/dcache_pkg.sv */
package dcache_pkg;

`include "mem_ops.svh"

   // a block holds 16 bytes
   localparam int BLOCK_OFFSET_BITS = 4;
   localparam int BLOCK_BYTES       = 1 << BLOCK_OFFSET_BITS;

   typedef logic [31:0]                addr_t;   // byte address
   typedef logic [31:0]                word_t;   // core data word
   typedef logic [BLOCK_BYTES*8-1:0]   block_t;  // byte 0 sits in bits 7:0
   typedef logic [2:0]                 mem_op_t;

   // loads
   localparam mem_op_t LB  = `MEM_LB;
   localparam mem_op_t LH  = `MEM_LH;
   localparam mem_op_t LW  = `MEM_LW;
   localparam mem_op_t LBU = `MEM_LBU;
   localparam mem_op_t LHU = `MEM_LHU;

   // stores
   localparam mem_op_t SB  = `MEM_SB;
   localparam mem_op_t SH  = `MEM_SH;
   localparam mem_op_t SW  = `MEM_SW;

endpackage

/* src/dcache_controller.sv */
`timescale 1ns/100ps

module dcache_controller
   import dcache_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  load_i,
   input  logic  store_i,
   input  addr_t addr_i,
   input  logic  hit_i,
   input  logic  dirty_i,
   input  addr_t victim_addr_i,
   input  logic  mem_free_i,
   input  logic  mem_ready_i,
   output logic  done_o,
   output logic  store_we_o,
   output logic  fill_o,
   output logic  mem_req_o,
   output logic  mem_we_o,
   output addr_t mem_addr_o
);

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITEBACK,
      REFILL,
      INSTALL
   } ctrl_state_t;

   ctrl_state_t state_r;
   ctrl_state_t state_nxt;
   logic        wb_ack_r;   // writeback has been acknowledged, read may follow
   addr_t       req_block;

   assign req_block = {addr_i[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

   always_comb begin
      state_nxt  = state_r;
      done_o     = 1'b0;
      store_we_o = 1'b0;
      fill_o     = 1'b0;
      mem_req_o  = 1'b0;
      mem_we_o   = 1'b0;

      case (state_r)
         IDLE: begin
            if (load_i || store_i) begin
               state_nxt = LOOKUP;
            end
         end

         LOOKUP: begin
            if (hit_i) begin
               done_o     = 1'b1;
               store_we_o = store_i;   // store merges into the line in the done cycle
               state_nxt  = IDLE;
            end else if (mem_free_i) begin
               mem_req_o = 1'b1;
               if (dirty_i) begin
                  mem_we_o  = 1'b1;     // victim must go out before the refill
                  state_nxt = WRITEBACK;
               end else begin
                  state_nxt = REFILL;
               end
            end
         end

         // the read request waits one cycle past the writeback acknowledge
         // so that two request pulses never touch
         WRITEBACK: begin
            if (wb_ack_r && mem_free_i) begin
               mem_req_o = 1'b1;
               state_nxt = REFILL;
            end
         end

         REFILL: begin
            if (mem_ready_i) begin
               fill_o    = 1'b1;
               state_nxt = INSTALL;
            end
         end

         INSTALL: state_nxt = LOOKUP;   // look up again, now a hit

         default: state_nxt = IDLE;
      endcase
   end

   // writeback carries the resident block address, everything else the request block
   assign mem_addr_o = mem_we_o ? victim_addr_i : req_block;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_r  <= IDLE;
         wb_ack_r <= 1'b0;
      end else begin
         state_r  <= state_nxt;
         wb_ack_r <= (state_nxt == WRITEBACK) && (wb_ack_r || mem_ready_i);
      end
   end

endmodule

/* src/dcache_array.sv */
`timescale 1ns/100ps

module dcache_array
   import dcache_pkg::*;
#(
   parameter int LINES_LOG2 = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  addr_t                  addr_i,
   input  logic                   fill_i,
   input  block_t                 fill_block_i,
   input  logic                   store_we_i,
   input  logic [BLOCK_BYTES-1:0] byte_en_i,
   input  block_t                 store_block_i,
   output logic                   hit_o,
   output logic                   dirty_o,
   output addr_t                  victim_addr_o,
   output block_t                 line_o
);

   localparam int LINES    = 1 << LINES_LOG2;
   localparam int TAG_BITS = 32 - BLOCK_OFFSET_BITS - LINES_LOG2;

   logic [TAG_BITS-1:0]   tag_mem [LINES];
   block_t                data_mem [LINES];
   logic [LINES-1:0]      valid_r;
   logic [LINES-1:0]      dirty_r;

   logic [LINES_LOG2-1:0] idx;
   logic [TAG_BITS-1:0]   tag;

   assign idx = addr_i[BLOCK_OFFSET_BITS +: LINES_LOG2];
   assign tag = addr_i[31 -: TAG_BITS];

   // lookup reads only registered storage
   assign hit_o   = valid_r[idx] && (tag_mem[idx] == tag);
   assign dirty_o = valid_r[idx] && dirty_r[idx];
   assign line_o  = data_mem[idx];

   // rebuild the block address of whatever sits in the indexed line
   assign victim_addr_o = {tag_mem[idx], idx, {BLOCK_OFFSET_BITS{1'b0}}};

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_r <= '0;
         dirty_r <= '0;
      end else if (fill_i) begin
         valid_r[idx] <= 1'b1;
         dirty_r[idx] <= 1'b0;   // fresh copy matches memory
      end else if (store_we_i) begin
         dirty_r[idx] <= 1'b1;
      end
   end

   // a refill writes tag and block while a store merges only the enabled bytes
   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= fill_block_i;
      end else if (store_we_i) begin
         for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (byte_en_i[b]) begin
               data_mem[idx][b*8 +: 8] <= store_block_i[b*8 +: 8];
            end
         end
      end
   end

endmodule

/* src/lane_align.sv */
`timescale 1ns/100ps

module lane_align
   import dcache_pkg::*;
(
   input  block_t                       line_i,
   input  logic [BLOCK_OFFSET_BITS-1:0] offset_i,
   input  mem_op_t                      op_i,
   input  word_t                        wdata_i,
   output word_t                        rdata_o,
   output logic [BLOCK_BYTES-1:0]       byte_en_o,
   output block_t                       store_block_o
);

   block_t                 lane;      // addressed byte moved down to bit 0
   logic [BLOCK_BYTES-1:0] be_base;

   assign lane = line_i >> {offset_i, 3'b000};

   always_comb begin
      case (op_i)
         LB:      rdata_o = {{24{lane[7]}}, lane[7:0]};
         LH:      rdata_o = {{16{lane[15]}}, lane[15:0]};
         LBU:     rdata_o = {24'd0, lane[7:0]};
         LHU:     rdata_o = {16'd0, lane[15:0]};
         default: rdata_o = lane[31:0];   // LW
      endcase
   end

   // accesses are aligned, so replicating the store value puts it in every lane
   always_comb begin
      case (op_i)
         SB: begin
            be_base       = BLOCK_BYTES'(4'b0001);
            store_block_o = {BLOCK_BYTES{wdata_i[7:0]}};
         end
         SH: begin
            be_base       = BLOCK_BYTES'(4'b0011);
            store_block_o = {(BLOCK_BYTES/2){wdata_i[15:0]}};
         end
         SW: begin
            be_base       = BLOCK_BYTES'(4'b1111);
            store_block_o = {(BLOCK_BYTES/4){wdata_i}};
         end
         default: begin
            be_base       = '0;   // loads write nothing
            store_block_o = {(BLOCK_BYTES/4){wdata_i}};
         end
      endcase
   end

   assign byte_en_o = be_base << offset_i;

endmodule

/* src/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
   import dcache_pkg::*;
#(
   parameter int LINES_LOG2 = 4   // 16 lines
) (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    load_i,
   input  logic    store_i,
   input  addr_t   addr_i,
   input  mem_op_t op_i,
   input  word_t   wdata_i,
   output word_t   rdata_o,
   output logic    done_o,
   input  logic    mem_free_i,
   input  logic    mem_ready_i,
   input  block_t  mem_rblock_i,
   output logic    mem_req_o,
   output logic    mem_we_o,
   output addr_t   mem_addr_o,
   output block_t  mem_wblock_o
);

   logic                   hit;
   logic                   dirty;
   addr_t                  victim_addr;
   block_t                 line;
   logic                   fill;
   logic                   store_we;
   logic [BLOCK_BYTES-1:0] byte_en;
   block_t                 store_block;

   assign mem_wblock_o = line;   // a writeback always sends the indexed line

   dcache_controller u_dcache_controller (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .load_i        (load_i),
      .store_i       (store_i),
      .addr_i        (addr_i),
      .hit_i         (hit),
      .dirty_i       (dirty),
      .victim_addr_i (victim_addr),
      .mem_free_i    (mem_free_i),
      .mem_ready_i   (mem_ready_i),
      .done_o        (done_o),
      .store_we_o    (store_we),
      .fill_o        (fill),
      .mem_req_o     (mem_req_o),
      .mem_we_o      (mem_we_o),
      .mem_addr_o    (mem_addr_o)
   );

   dcache_array #(
      .LINES_LOG2 (LINES_LOG2)
   ) u_dcache_array (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .addr_i        (addr_i),
      .fill_i        (fill),
      .fill_block_i  (mem_rblock_i),
      .store_we_i    (store_we),
      .byte_en_i     (byte_en),
      .store_block_i (store_block),
      .hit_o         (hit),
      .dirty_o       (dirty),
      .victim_addr_o (victim_addr),
      .line_o        (line)
   );

   lane_align u_lane_align (
      .line_i        (line),
      .offset_i      (addr_i[BLOCK_OFFSET_BITS-1:0]),
      .op_i          (op_i),
      .wdata_i       (wdata_i),
      .rdata_o       (rdata_o),
      .byte_en_o     (byte_en),
      .store_block_o (store_block)
   );

endmodule

/* bench/dcache_checker.sv */
`timescale 1ns/100ps

module dcache_checker (
   input logic clk_i,
   input logic rst_i,
   input logic done_i,
   input logic mem_req_i,
   input logic mem_free_i,
   input logic mem_ready_i,
   input logic hit_i,
   input logic fill_i
);

   a_done_not_with_req: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(done_i && mem_req_i))
      else $error("done and a memory request in the same cycle");

   // requests are single cycle pulses
   a_req_is_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_req_i |=> !mem_req_i)
      else $error("memory request held for two cycles");

   a_req_needs_free: assert property (@(posedge clk_i) disable iff (!rst_i)
      mem_req_i |-> mem_free_i)
      else $error("memory request while memory is busy");

   a_done_on_hit: assert property (@(posedge clk_i) disable iff (!rst_i)
      done_i |-> hit_i)
      else $error("done without a hit");

   a_fill_on_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
      fill_i |-> mem_ready_i)   // refill data only exists with the ready pulse
      else $error("line fill without memory ready");

endmodule

bind dcache_controller dcache_checker u_dcache_checker (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .done_i      (done_o),
   .mem_req_i   (mem_req_o),
   .mem_free_i  (mem_free_i),
   .mem_ready_i (mem_ready_i),
   .hit_i       (hit_i),
   .fill_i      (fill_o)
);

/* bench/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
   import dcache_pkg::*;
();

   localparam int MAX_TESTS = 64;
   localparam int FIELDS    = 7;    // words per access record in the tests file
   localparam int CLK_HALF  = 10;

   logic        clk_i;
   logic        rst_i;
   logic        load_i;
   logic        store_i;
   addr_t       addr_i;
   mem_op_t     op_i;
   word_t       wdata_i;
   word_t       rdata_o;
   logic        done_o;
   logic        mem_free_i;
   logic        mem_ready_i;
   block_t      mem_rblock_i;
   logic        mem_req_o;
   logic        mem_we_o;
   addr_t       mem_addr_o;
   block_t      mem_wblock_o;

   block_t      mem_model [256];            // 4 KiB of main memory
   logic [31:0] test_words [MAX_TESTS*FIELDS];
   int          num_tests = 0;
   int          cur_test  = -1;
   int          mem_reads;
   int          mem_writes;
   logic [16:0] lfsr_state;

   dcache_top #(
      .LINES_LOG2 (4)
   ) u_dcache_top (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .load_i       (load_i),
      .store_i      (store_i),
      .addr_i       (addr_i),
      .op_i         (op_i),
      .wdata_i      (wdata_i),
      .rdata_o      (rdata_o),
      .done_o       (done_o),
      .mem_free_i   (mem_free_i),
      .mem_ready_i  (mem_ready_i),
      .mem_rblock_i (mem_rblock_i),
      .mem_req_o    (mem_req_o),
      .mem_we_o     (mem_we_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wblock_o (mem_wblock_o)
   );

   // one step of the x^17 + x^14 + 1 register per random bit
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #2;
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0d ns in test %0d: %s is %h, expected %h",
                  $time, cur_test, name, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at the first error");
      end
   endtask

   // holds one core access until done_o and then compares data and traffic
   task automatic run_access(input int t);
      logic [31:0] kind;
      logic [31:0] exp_rdata;
      logic [31:0] exp_reads;
      logic [31:0] exp_writes;
      int          reads_before;
      int          writes_before;
      int          cycles;
      kind          = test_words[t*FIELDS];
      exp_rdata     = test_words[t*FIELDS+4];
      exp_reads     = test_words[t*FIELDS+5];
      exp_writes    = test_words[t*FIELDS+6];
      reads_before  = mem_reads;
      writes_before = mem_writes;
      load_i  = (kind == 32'd0);
      store_i = (kind != 32'd0);
      op_i    = test_words[t*FIELDS+1][2:0];
      addr_i  = test_words[t*FIELDS+2];
      wdata_i = test_words[t*FIELDS+3];
      cycles  = 0;
      @(negedge clk_i);   // controller still in IDLE here
      while (!done_o) begin
         @(negedge clk_i);
         cycles++;
      end
      if (kind == 32'd0) begin
         check_value("rdata_o", rdata_o, exp_rdata);
      end
      check_value("memory reads", mem_reads - reads_before, exp_reads);
      check_value("memory writebacks", mem_writes - writes_before, exp_writes);
      if (exp_reads == 32'd0 && exp_writes == 32'd0) begin
         check_value("hit latency in cycles", cycles, 32'd1);
      end
      next_cycle();
      load_i  = 1'b0;
      store_i = 1'b0;
   endtask

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   initial begin : memory_model
      logic       we;
      logic [7:0] blk;
      block_t     wblock;
      logic [2:0] lat_bits;
      mem_free_i   = 1'b1;
      mem_ready_i  = 1'b0;
      mem_rblock_i = '0;
      mem_reads    = 0;
      mem_writes   = 0;
      lfsr_state   = 17'd70487;
      lat_bits     = 3'd0;
      for (int b = 0; b < 256; b++) begin
         for (int w = 0; w < 4; w++) begin
            mem_model[b][w*32 +: 32] = (b * 16 + w * 4) ^ 32'hC0DE0000;
         end
      end
      forever begin
         @(negedge clk_i);
         if (mem_req_o) begin
            we     = mem_we_o;
            blk    = mem_addr_o[11:4];
            wblock = mem_wblock_o;
            for (int i = 0; i < 3; i++) begin
               lfsr_state = lfsr_next(lfsr_state);
               lat_bits   = {lat_bits[1:0], lfsr_state[0]};
            end
            next_cycle();
            mem_free_i = 1'b0;             // busy until the transfer ends
            repeat (lat_bits) next_cycle();
            if (we) begin
               mem_model[blk] = wblock;
               mem_writes++;
            end else begin
               mem_rblock_i = mem_model[blk];
               mem_reads++;
            end
            mem_ready_i = 1'b1;
            next_cycle();
            mem_ready_i = 1'b0;
            mem_free_i  = 1'b1;
         end
      end
   end

   initial begin : watchdog
      wait (num_tests > 0);
      repeat (num_tests * 40 + 10) @(posedge clk_i);
      $display("timeout: the accesses did not complete within %0d cycles",
               num_tests * 40 + 10);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin : main
      int n;
      rst_i   = 1'b0;
      load_i  = 1'b1;   // a load held during reset must not start a lookup
      store_i = 1'b0;
      addr_i  = '0;
      op_i    = LW;
      wdata_i = '0;
      for (int i = 0; i < MAX_TESTS * FIELDS; i++) begin
         test_words[i] = '1;              // all ones marks the end of the records
      end
      $readmemh("bench/dcache_tests.txt", test_words);
      n = 0;
      while (n < MAX_TESTS && test_words[n*FIELDS] != 32'hFFFF_FFFF) begin
         n++;
      end
      if (n == 0) begin
         $display("no access records could be read from bench/dcache_tests.txt");
         $display("CHECKS FAILED");
         $fatal(1, "empty test file");
      end
      num_tests = n;

      repeat (5) begin
         next_cycle();
         check_value("done_o", 32'(done_o), 32'd0);
         check_value("mem_req_o", 32'(mem_req_o), 32'd0);
      end
      load_i = 1'b0;
      rst_i  = 1'b1;
      repeat (2) begin
         @(negedge clk_i);
         check_value("done_o", 32'(done_o), 32'd0);
         check_value("mem_req_o", 32'(mem_req_o), 32'd0);
      end
      next_cycle();

      for (int t = 0; t < num_tests; t++) begin
         cur_test = t;
         run_access(t);
      end
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* bench/dcache_tests.txt */
// kind (0 load, 1 store), op, address, store data, expected load data, reads, writebacks
// op codes: 0 LB, 1 LH, 2 LW, 3 LBU, 4 LHU, 5 SB, 6 SH, 7 SW
0 2 00000100 00000000 c0de0100 1 0
0 2 00000104 00000000 c0de0104 0 0
0 0 00000103 00000000 ffffffc0 0 0
0 3 00000103 00000000 000000c0 0 0
0 1 00000102 00000000 ffffc0de 0 0
0 4 0000010a 00000000 0000c0de 0 0
0 0 00000101 00000000 00000001 0 0
0 1 00000108 00000000 00000108 0 0
0 0 00000226 00000000 ffffffde 1 0
0 4 0000033e 00000000 0000c0de 1 0
0 1 0000044c 00000000 0000044c 1 0
0 3 0000055f 00000000 000000c0 1 0
0 0 00000550 00000000 00000050 0 0
1 5 00000105 000000a5 00000000 0 0
0 2 00000104 00000000 c0dea504 0 0
1 6 0000010e 00001234 00000000 0 0
0 2 0000010c 00000000 1234010c 0 0
1 7 00000108 deadbeef 00000000 0 0
0 2 00000108 00000000 deadbeef 0 0
0 3 00000109 00000000 000000be 0 0
0 1 0000010e 00000000 00001234 0 0
0 2 00000200 00000000 c0de0200 1 1
0 2 00000104 00000000 c0dea504 1 0
0 2 0000010c 00000000 1234010c 0 0
0 2 00000108 00000000 deadbeef 0 0
0 2 00000a20 00000000 c0de0a20 1 0
0 3 00000226 00000000 000000de 1 0
1 7 00000630 0badf00d 00000000 1 0
0 2 00000630 00000000 0badf00d 0 0
0 2 00000734 00000000 c0de0734 1 1
0 2 00000630 00000000 0badf00d 1 0
1 5 00000633 00000080 00000000 0 0
0 0 00000633 00000000 ffffff80 0 0
0 1 00000632 00000000 ffff80ad 0 0

/* flist.f */
+incdir+include
src/dcache_pkg.sv
src/dcache_controller.sv
src/dcache_array.sv
src/lane_align.sv
src/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the dcache testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module dcache_tb -f flist.f -o dcache_sim

status=0
./obj_dir/dcache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
if [ "$status" -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
echo "simulation passed"
